// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ======================================================================
// Datapath and register file sizing
// ======================================================================
`define CPU_XLEN      32
`define CPU_NUM_GPR   8
`define CPU_GPR_IDX_W 3

// ======================================================================
// Instruction word fields
// ======================================================================
`define CPU_IMM_W     16
`define CPU_OPCODE_W  4

`endif

// File: verilog/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

   `include "cpu_settings.svh"

   typedef logic [`CPU_XLEN-1:0]      data_t;
   typedef logic [`CPU_GPR_IDX_W-1:0] gpr_idx_t;

   // Undefined codes fall through to NOP in decode
   typedef enum logic [`CPU_OPCODE_W-1:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_OR   = 4'h4,
      OP_XOR  = 4'h5,
      OP_ADDI = 4'h6,
      OP_LI   = 4'h7
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_PASS_B = 3'd5
   } alu_op_e;

   // Instruction word with one spare bit between register fields
   typedef struct packed {
      logic [`CPU_OPCODE_W-1:0] opcode;
      logic                     spare0;
      gpr_idx_t                 dest;
      logic                     spare1;
      gpr_idx_t                 src1;
      logic                     spare2;
      gpr_idx_t                 src2;
      logic [`CPU_IMM_W-1:0]    imm;
   } instr_t;

   typedef struct packed {
      logic zero;
      logic sign;
      logic carry;
      logic overflow;
   } flags_t;

endpackage

`default_nettype wire

// File: verilog/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

   `include "cpu_settings.svh"

   // Decode latch contents
   typedef struct packed {
      cpu_isa_pkg::alu_op_e  alu_op;
      cpu_isa_pkg::gpr_idx_t src1;
      cpu_isa_pkg::gpr_idx_t src2;
      cpu_isa_pkg::gpr_idx_t dest;
      logic                  uses_src1;
      logic                  uses_src2;
      logic                  use_imm;
      cpu_isa_pkg::data_t    imm;
      logic                  writes_dest;
      logic                  writes_flags;
   } decoded_t;

   // Issue latch contents with operands already read
   typedef struct packed {
      cpu_isa_pkg::alu_op_e  alu_op;
      cpu_isa_pkg::data_t    a;
      cpu_isa_pkg::data_t    b;
      cpu_isa_pkg::gpr_idx_t dest;
      logic                  writes_dest;
      logic                  writes_flags;
   } issue_t;

   // Result latch contents
   typedef struct packed {
      cpu_isa_pkg::gpr_idx_t dest;
      logic                  writes_dest;
      logic                  writes_flags;
      cpu_isa_pkg::data_t    result;
      cpu_isa_pkg::flags_t   flags;
   } result_t;

   typedef struct packed {
      logic                  en;
      cpu_isa_pkg::gpr_idx_t idx;
      cpu_isa_pkg::data_t    data;
   } gpr_write_t;

endpackage

`default_nettype wire

// File: verilog/pipe_latch.sv
`default_nettype none

module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   input  payload_t in_payload,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_payload,
   input  logic     out_ready
);

   logic     valid_q;
   payload_t payload_q;

   // Accept when empty or when the held item leaves this cycle
   assign in_ready    = !valid_q || out_ready;
   assign out_valid   = valid_q;
   assign out_payload = payload_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         payload_q <= in_payload;
      end
   end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

`include "cpu_settings.svh"

module decode_stage (
   input  logic                   in_valid,
   input  cpu_isa_pkg::instr_t    in_instr,
   output logic                   in_ready,
   output logic                   dec_valid,
   output cpu_pipe_pkg::decoded_t dec,
   input  logic                   dec_ready
);

   cpu_isa_pkg::alu_op_e alu_op;
   cpu_isa_pkg::data_t   imm_ext;
   logic                 is_rr;
   logic                 is_addi;
   logic                 is_li;

   // Combinational stage passes the handshake straight through
   assign dec_valid = in_valid;
   assign in_ready  = dec_ready;

   assign imm_ext = {{(`CPU_XLEN-`CPU_IMM_W){in_instr.imm[`CPU_IMM_W-1]}}, in_instr.imm};

   // Opcode class and ALU operation
   always_comb begin
      alu_op  = cpu_isa_pkg::ALU_PASS_B;
      is_rr   = 1'b1;
      is_addi = 1'b0;
      is_li   = 1'b0;
      case (in_instr.opcode)
         cpu_isa_pkg::OP_ADD: alu_op = cpu_isa_pkg::ALU_ADD;
         cpu_isa_pkg::OP_SUB: alu_op = cpu_isa_pkg::ALU_SUB;
         cpu_isa_pkg::OP_AND: alu_op = cpu_isa_pkg::ALU_AND;
         cpu_isa_pkg::OP_OR:  alu_op = cpu_isa_pkg::ALU_OR;
         cpu_isa_pkg::OP_XOR: alu_op = cpu_isa_pkg::ALU_XOR;
         cpu_isa_pkg::OP_ADDI: begin
            alu_op  = cpu_isa_pkg::ALU_ADD;
            is_rr   = 1'b0;
            is_addi = 1'b1;
         end
         cpu_isa_pkg::OP_LI: begin
            is_rr = 1'b0;
            is_li = 1'b1;
         end
         // NOP and undefined codes touch nothing
         default: is_rr = 1'b0;
      endcase
   end

   assign dec = '{alu_op:       alu_op,
                  src1:         in_instr.src1,
                  src2:         in_instr.src2,
                  dest:         in_instr.dest,
                  uses_src1:    is_rr || is_addi,
                  uses_src2:    is_rr,
                  use_imm:      is_addi || is_li,
                  imm:          imm_ext,
                  writes_dest:  is_rr || is_addi || is_li,
                  writes_flags: is_rr || is_addi};

endmodule

`default_nettype wire

// File: verilog/operand_stage.sv
`default_nettype none

`include "cpu_settings.svh"

module operand_stage (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     dec_valid,
   input  cpu_pipe_pkg::decoded_t   dec,
   output logic                     dec_ready,
   output logic                     iss_valid,
   output cpu_pipe_pkg::issue_t     iss,
   input  logic                     iss_ready,
   input  cpu_pipe_pkg::gpr_write_t gpr_wr
);

   cpu_isa_pkg::data_t      gpr_q [`CPU_NUM_GPR];
   logic [`CPU_NUM_GPR-1:0] busy_q;
   cpu_isa_pkg::data_t      opnd_a;
   cpu_isa_pkg::data_t      opnd_b;
   logic                    hazard;
   logic                    issue;

   // ======================================================================
   // Scoreboard check
   // ======================================================================

   // Sources and destination must all be free of older writers
   assign hazard = (dec.uses_src1   && busy_q[dec.src1]) ||
                   (dec.uses_src2   && busy_q[dec.src2]) ||
                   (dec.writes_dest && busy_q[dec.dest]);

   assign iss_valid = dec_valid && !hazard;
   assign dec_ready = iss_ready && !hazard;
   assign issue     = iss_valid && iss_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= '0;
      end else begin
         if (gpr_wr.en) begin
            busy_q[gpr_wr.idx] <= 1'b0;
         end
         // An issuing dest is never busy, so it is never the one cleared here
         if (issue && dec.writes_dest) begin
            busy_q[dec.dest] <= 1'b1;
         end
      end
   end

   // ======================================================================
   // Register file with two reads and one write
   // ======================================================================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CPU_NUM_GPR; i++) begin
            gpr_q[i] <= '0;
         end
      end else if (gpr_wr.en) begin
         gpr_q[gpr_wr.idx] <= gpr_wr.data;
      end
   end

   // Unused operands read as zero
   assign opnd_a = dec.uses_src1 ? gpr_q[dec.src1] : '0;

   always_comb begin
      if (dec.use_imm) begin
         opnd_b = dec.imm;
      end else if (dec.uses_src2) begin
         opnd_b = gpr_q[dec.src2];
      end else begin
         opnd_b = '0;
      end
   end

   assign iss = '{alu_op:       dec.alu_op,
                  a:            opnd_a,
                  b:            opnd_b,
                  dest:         dec.dest,
                  writes_dest:  dec.writes_dest,
                  writes_flags: dec.writes_flags};

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`default_nettype none

`include "cpu_settings.svh"

module execute_stage (
   input  logic                  iss_valid,
   input  cpu_pipe_pkg::issue_t  iss,
   output logic                  iss_ready,
   output logic                  res_valid,
   output cpu_pipe_pkg::result_t res,
   input  logic                  res_ready
);

   logic [`CPU_XLEN:0]  sum;
   logic [`CPU_XLEN:0]  diff;
   cpu_isa_pkg::data_t  result;
   cpu_isa_pkg::flags_t flags;

   assign res_valid = iss_valid;
   assign iss_ready = res_ready;

   // Extra top bit holds carry out or borrow
   assign sum  = {1'b0, iss.a} + {1'b0, iss.b};
   assign diff = {1'b0, iss.a} - {1'b0, iss.b};

   always_comb begin
      flags.carry    = 1'b0;
      flags.overflow = 1'b0;
      case (iss.alu_op)
         cpu_isa_pkg::ALU_ADD: begin
            result         = sum[`CPU_XLEN-1:0];
            flags.carry    = sum[`CPU_XLEN];
            flags.overflow = (iss.a[`CPU_XLEN-1] == iss.b[`CPU_XLEN-1]) &&
                             (result[`CPU_XLEN-1] != iss.a[`CPU_XLEN-1]);
         end
         cpu_isa_pkg::ALU_SUB: begin
            result         = diff[`CPU_XLEN-1:0];
            flags.carry    = diff[`CPU_XLEN];
            flags.overflow = (iss.a[`CPU_XLEN-1] != iss.b[`CPU_XLEN-1]) &&
                             (result[`CPU_XLEN-1] != iss.a[`CPU_XLEN-1]);
         end
         cpu_isa_pkg::ALU_AND: result = iss.a & iss.b;
         cpu_isa_pkg::ALU_OR:  result = iss.a | iss.b;
         cpu_isa_pkg::ALU_XOR: result = iss.a ^ iss.b;
         default:              result = iss.b;
      endcase
      flags.zero = (result == '0);
      flags.sign = result[`CPU_XLEN-1];
   end

   assign res = '{dest:         iss.dest,
                  writes_dest:  iss.writes_dest,
                  writes_flags: iss.writes_flags,
                  result:       result,
                  flags:        flags};

endmodule

`default_nettype wire

// File: verilog/writeback_stage.sv
`default_nettype none

module writeback_stage (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     res_valid,
   input  cpu_pipe_pkg::result_t    res,
   output logic                     res_ready,
   output logic                     wb_valid,
   output cpu_isa_pkg::gpr_idx_t    wb_dest,
   output logic                     wb_we,
   output cpu_isa_pkg::data_t       wb_data,
   output cpu_isa_pkg::flags_t      wb_flags,
   input  logic                     wb_ready,
   output cpu_pipe_pkg::gpr_write_t gpr_wr
);

   cpu_isa_pkg::flags_t flags_q;
   logic                retire;

   assign retire    = res_valid && wb_ready;
   assign res_ready = wb_ready;

   // Retirement port mirrors the result latch
   assign wb_valid = res_valid;
   assign wb_dest  = res.dest;
   assign wb_we    = res.writes_dest;
   assign wb_data  = res.result;

   // Show flags as they stand after this retirement
   assign wb_flags = (res_valid && res.writes_flags) ? res.flags : flags_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flags_q <= '0;
      end else if (retire && res.writes_flags) begin
         flags_q <= res.flags;
      end
   end

   // Register write also frees the scoreboard entry
   assign gpr_wr = '{en: retire && res.writes_dest, idx: res.dest, data: res.result};

endmodule

`default_nettype wire

// File: verilog/cpu_pipeline.sv
`default_nettype none

module cpu_pipeline (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  in_valid,
   input  cpu_isa_pkg::instr_t   in_instr,
   output logic                  in_ready,
   output logic                  wb_valid,
   output cpu_isa_pkg::gpr_idx_t wb_dest,
   output logic                  wb_we,
   output cpu_isa_pkg::data_t    wb_data,
   output cpu_isa_pkg::flags_t   wb_flags,
   input  logic                  wb_ready
);

   // Decode to decode latch
   logic                     dec_valid;
   logic                     dec_ready;
   cpu_pipe_pkg::decoded_t   dec;
   // Decode latch to operand read
   logic                     opr_valid;
   logic                     opr_ready;
   cpu_pipe_pkg::decoded_t   opr_dec;
   // Operand read to issue latch
   logic                     iss_valid;
   logic                     iss_ready;
   cpu_pipe_pkg::issue_t     iss;
   // Issue latch to execute
   logic                     exe_valid;
   logic                     exe_ready;
   cpu_pipe_pkg::issue_t     exe_iss;
   // Execute to result latch
   logic                     res_valid;
   logic                     res_ready;
   cpu_pipe_pkg::result_t    res;
   // Result latch to writeback
   logic                     wbk_valid;
   logic                     wbk_ready;
   cpu_pipe_pkg::result_t    wbk_res;
   cpu_pipe_pkg::gpr_write_t gpr_wr;

   decode_stage u_decode (
      .in_valid, .in_instr, .in_ready, .dec_valid, .dec, .dec_ready
   );

   pipe_latch #(.payload_t(cpu_pipe_pkg::decoded_t)) u_dec_latch (
      .clk, .arst_n,
      .in_valid (dec_valid), .in_payload (dec),     .in_ready  (dec_ready),
      .out_valid(opr_valid), .out_payload(opr_dec), .out_ready (opr_ready)
   );

   operand_stage u_operand (
      .clk, .arst_n,
      .dec_valid(opr_valid), .dec(opr_dec), .dec_ready(opr_ready),
      .iss_valid, .iss, .iss_ready, .gpr_wr
   );

   pipe_latch #(.payload_t(cpu_pipe_pkg::issue_t)) u_iss_latch (
      .clk, .arst_n,
      .in_valid (iss_valid), .in_payload (iss),     .in_ready  (iss_ready),
      .out_valid(exe_valid), .out_payload(exe_iss), .out_ready (exe_ready)
   );

   execute_stage u_execute (
      .iss_valid(exe_valid), .iss(exe_iss), .iss_ready(exe_ready),
      .res_valid, .res, .res_ready
   );

   pipe_latch #(.payload_t(cpu_pipe_pkg::result_t)) u_res_latch (
      .clk, .arst_n,
      .in_valid (res_valid), .in_payload (res),     .in_ready  (res_ready),
      .out_valid(wbk_valid), .out_payload(wbk_res), .out_ready (wbk_ready)
   );

   writeback_stage u_writeback (
      .clk, .arst_n,
      .res_valid(wbk_valid), .res(wbk_res), .res_ready(wbk_ready),
      .wb_valid, .wb_dest, .wb_we, .wb_data, .wb_flags, .wb_ready, .gpr_wr
   );

endmodule

`default_nettype wire

// File: tb/cpu_pipeline_assert.sv
`default_nettype none

module cpu_pipeline_assert (
   input wire logic                  clk,
   input wire logic                  arst_n,
   input wire logic                  in_valid,
   input wire logic                  wb_valid,
   input wire logic                  wb_ready,
   input wire cpu_isa_pkg::gpr_idx_t wb_dest,
   input wire logic                  wb_we,
   input wire cpu_isa_pkg::data_t    wb_data,
   input wire cpu_isa_pkg::flags_t   wb_flags
);

   timeunit 1ns;
   timeprecision 1ps;

   // Nothing retires while the pipeline is held in reset
   wb_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_valid)
      else $error("wb_valid high during reset");

   // Stalled retirement keeps its outputs
   wb_stable_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_valid && !wb_ready) |=> (wb_valid && $stable({wb_dest, wb_we, wb_data, wb_flags})))
      else $error("wb outputs changed while stalled");

   handshake_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown({in_valid, wb_valid}))
      else $error("in_valid or wb_valid unknown after reset");

endmodule

bind cpu_pipeline cpu_pipeline_assert u_assert (.*);

`default_nettype wire

// File: tb/cpu_pipeline_tb.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_pipeline_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD      = 20;
   localparam int NUM_INSTR       = 400;
   localparam int WATCHDOG_CYCLES = 20 * NUM_INSTR + 5;

   typedef struct packed {
      cpu_isa_pkg::gpr_idx_t dest;
      logic                  we;
      cpu_isa_pkg::data_t    data;
      cpu_isa_pkg::flags_t   flags;
   } expect_t;

   logic                  clk;
   logic                  arst_n;
   logic                  in_valid;
   cpu_isa_pkg::instr_t   in_instr;
   logic                  in_ready;
   logic                  wb_valid;
   cpu_isa_pkg::gpr_idx_t wb_dest;
   logic                  wb_we;
   cpu_isa_pkg::data_t    wb_data;
   cpu_isa_pkg::flags_t   wb_flags;
   logic                  wb_ready;

   logic [31:0]         rng_state = 32'hdef1_00e9;
   cpu_isa_pkg::data_t  model_gpr [`CPU_NUM_GPR];
   cpu_isa_pkg::flags_t model_flags;
   expect_t             exp_q [$];
   logic                took;
   int                  accepted;
   int                  retired;
   int                  checks;
   int                  errors;

   cpu_pipeline dut (
      .clk, .arst_n, .in_valid, .in_instr, .in_ready,
      .wb_valid, .wb_dest, .wb_we, .wb_data, .wb_flags, .wb_ready
   );

   // ======================================================================
   // Random source and stimulus helpers
   // ======================================================================

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic cpu_isa_pkg::instr_t random_instr();
      cpu_isa_pkg::instr_t ins;
      logic [31:0]         sel;
      sel = next_rand();
      ins = next_rand();
      // One in eight codes is undefined
      ins.opcode = {(sel[2:0] == 3'd0), sel[5:3]};
      // Only r0..r3, so most instructions depend on a recent one
      ins.dest = {1'b0, sel[9:8]};
      ins.src1 = {1'b0, sel[11:10]};
      ins.src2 = {1'b0, sel[13:12]};
      if (sel[15:14] == 2'd0) begin
         ins.imm = {{12{sel[16]}}, sel[20:17]};
      end
      return ins;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // ======================================================================
   // In-order reference model
   // ======================================================================

   task automatic model_accept(input cpu_isa_pkg::instr_t ins);
      cpu_isa_pkg::data_t a;
      cpu_isa_pkg::data_t b;
      cpu_isa_pkg::data_t imm_ext;
      cpu_isa_pkg::data_t r;
      logic [`CPU_XLEN:0] swide;
      logic               cy;
      logic               ov;
      logic               we;
      logic               wf;
      expect_t            e;
      imm_ext = {{(`CPU_XLEN-`CPU_IMM_W){ins.imm[`CPU_IMM_W-1]}}, ins.imm};
      a       = model_gpr[ins.src1];
      b       = (ins.opcode == cpu_isa_pkg::OP_ADDI) ? imm_ext : model_gpr[ins.src2];
      r       = '0;
      cy      = 1'b0;
      ov      = 1'b0;
      we      = 1'b1;
      wf      = 1'b1;
      // Exact signed result in one extra bit overflows when its top two bits differ
      case (ins.opcode)
         cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_ADDI: begin
            r     = a + b;
            cy    = (r < a);
            swide = {a[`CPU_XLEN-1], a} + {b[`CPU_XLEN-1], b};
            ov    = swide[`CPU_XLEN] != swide[`CPU_XLEN-1];
         end
         cpu_isa_pkg::OP_SUB: begin
            r     = a - b;
            cy    = (a < b);
            swide = {a[`CPU_XLEN-1], a} - {b[`CPU_XLEN-1], b};
            ov    = swide[`CPU_XLEN] != swide[`CPU_XLEN-1];
         end
         cpu_isa_pkg::OP_AND: r = a & b;
         cpu_isa_pkg::OP_OR:  r = a | b;
         cpu_isa_pkg::OP_XOR: r = a ^ b;
         cpu_isa_pkg::OP_LI: begin
            r  = imm_ext;
            wf = 1'b0;
         end
         default: begin
            we = 1'b0;
            wf = 1'b0;
         end
      endcase
      if (we) begin
         model_gpr[ins.dest] = r;
      end
      if (wf) begin
         model_flags = '{zero: (r == '0), sign: r[`CPU_XLEN-1], carry: cy, overflow: ov};
      end
      e = '{dest: ins.dest, we: we, data: r, flags: model_flags};
      exp_q.push_back(e);
   endtask

   task automatic check_retire();
      expect_t e;
      if (exp_q.size() == 0) begin
         errors++;
         $display("Retirement at %0d ns with no instruction outstanding", $time);
      end else begin
         e = exp_q.pop_front();
         check_value("wb_we", 32'(wb_we), 32'(e.we));
         // Destination and data only mean something for writers
         if (e.we) begin
            check_value("wb_dest", 32'(wb_dest), 32'(e.dest));
            check_value("wb_data", wb_data, e.data);
         end
         check_value("wb_flags", 32'(wb_flags), 32'(e.flags));
      end
      retired++;
   endtask

   // ======================================================================
   // Clock, monitor, stimulus and watchdog
   // ======================================================================

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Sampled mid-cycle to match what the next rising edge transfers
   always @(negedge clk) begin : monitor
      if (arst_n) begin
         if (wb_valid && wb_ready) begin
            check_retire();
         end
         took = in_valid && in_ready;
         if (took) begin
            model_accept(in_instr);
            accepted++;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: run did not finish, %0d accepted, %0d retired", accepted, retired);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin : stimulus
      arst_n      = 1'b1;
      in_valid    = 1'b0;
      in_instr    = '0;
      wb_ready    = 1'b0;
      took        = 1'b0;
      accepted    = 0;
      retired     = 0;
      checks      = 0;
      errors      = 0;
      model_flags = '0;
      for (int i = 0; i < `CPU_NUM_GPR; i++) begin
         model_gpr[i] = '0;
      end
      #1;
      arst_n = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      arst_n = 1'b1;
      @(negedge clk);
      check_value("wb_valid after reset", 32'(wb_valid), 32'd0);
      check_value("in_ready after reset", 32'(in_ready), 32'd1);

      // Random stream with gaps on both sides
      while (accepted < NUM_INSTR) begin
         @(posedge clk);
         #2;
         wb_ready = (next_rand() & 32'd3) != 32'd0;
         if (accepted >= NUM_INSTR) begin
            in_valid = 1'b0;
         end else if (!in_valid || took) begin
            in_valid = (next_rand() & 32'd3) != 32'd0;
            in_instr = random_instr();
         end
      end
      in_valid = 1'b0;

      while (retired < accepted) begin
         @(posedge clk);
         #2;
         wb_ready = (next_rand() & 32'd3) != 32'd0;
      end
      wb_ready = 1'b1;
      repeat (4) @(posedge clk);
      check_value("retired count", 32'(retired), 32'(accepted));
      check_value("outstanding entries", 32'(exp_q.size()), 32'd0);

      $display("Checks %0d, errors %0d, accepted %0d, retired %0d",
               checks, errors, accepted, retired);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/pipe_latch.sv
verilog/decode_stage.sv
verilog/operand_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/cpu_pipeline.sv
tb/cpu_pipeline_assert.sv
tb/cpu_pipeline_tb.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert
TOP       := cpu_pipeline_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation completed without errors"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
